//--- source/serdes_macros.svh
`ifndef SERDES_MACROS_SVH
`define SERDES_MACROS_SVH

// words per pattern frame, comma included.
`define COMMA_PERIOD 16
// commas at one offset before the boundary is trusted.
`define LOCK_COMMAS  3
`define LOCK_TIMEOUT 512
`define LEN_W        16

// symbols are {abcdei, fghj}, bit 9 goes out first.
`define K28_5_RDN    10'b0011111010
`define K28_5_RDP    10'b1100000101
`define K28_5_BYTE   8'hBC

`endif

//--- source/serdes_pkg.sv
`default_nettype none
package serdes_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_lock,
        st_run,
        st_done,
        st_release
    } ctrl_state_t;

    typedef enum logic [1:0] {
        sym_data,
        sym_comma,
        sym_invalid
    } sym_kind_t;

    // abcdei in rd- form, a in bit 5; encoder and decoder share this table.
    function automatic logic [5:0] enc_5b6b(input logic [4:0] x);
        case (x)
            5'd0:  return 6'b100111;
            5'd1:  return 6'b011101;
            5'd2:  return 6'b101101;
            5'd3:  return 6'b110001;
            5'd4:  return 6'b110101;
            5'd5:  return 6'b101001;
            5'd6:  return 6'b011001;
            5'd7:  return 6'b111000;
            5'd8:  return 6'b111001;
            5'd9:  return 6'b100101;
            5'd10: return 6'b010101;
            5'd11: return 6'b110100;
            5'd12: return 6'b001101;
            5'd13: return 6'b101100;
            5'd14: return 6'b011100;
            5'd15: return 6'b010111;
            5'd16: return 6'b011011;
            5'd17: return 6'b100011;
            5'd18: return 6'b010011;
            5'd19: return 6'b110010;
            5'd20: return 6'b001011;
            5'd21: return 6'b101010;
            5'd22: return 6'b011010;
            5'd23: return 6'b111010;
            5'd24: return 6'b110011;
            5'd25: return 6'b100110;
            5'd26: return 6'b010110;
            5'd27: return 6'b110110;
            5'd28: return 6'b001110;
            5'd29: return 6'b101110;
            5'd30: return 6'b011110;
            5'd31: return 6'b101011;
        endcase
    endfunction

    // fghj in rd- form.
    function automatic logic [3:0] enc_3b4b(input logic [2:0] y);
        case (y)
            3'd0: return 4'b1011;
            3'd1: return 4'b1001;
            3'd2: return 4'b0101;
            3'd3: return 4'b1100;
            3'd4: return 4'b1101;
            3'd5: return 4'b1010;
            3'd6: return 4'b0110;
            3'd7: return 4'b1110; // primary x.7.
        endcase
    endfunction

endpackage
`default_nettype wire

//--- source/link_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "serdes_macros.svh"

module link_ctrl (
    input  wire               tx_pclk,
    input  wire               rst,
    input  wire               test_req,
    input  wire  [`LEN_W-1:0] test_len,
    input  wire               locked,
    input  wire               word_tick,
    input  wire  [`LEN_W-1:0] checker_errs,
    output logic              test_ack,
    output logic [`LEN_W-1:0] err_count,
    output logic              no_lock,
    output logic              gen_en,
    output logic              chk_en,
    output logic              chk_clear,
    output logic              align_restart
);

    serdes_pkg::ctrl_state_t state;
    logic [`LEN_W-1:0]       cnt; // lock wait cycles, then checked words.

    assign test_ack      = (state == serdes_pkg::st_done);
    assign chk_en        = (state == serdes_pkg::st_run);
    assign gen_en        = (state == serdes_pkg::st_wait_lock) || chk_en;
    assign chk_clear     = (state == serdes_pkg::st_idle) && test_req;
    assign align_restart = chk_clear; // every run starts from a fresh lock.

    always_ff @(posedge tx_pclk) begin
        if (rst) begin
            state     <= serdes_pkg::st_idle;
            cnt       <= '0;
            err_count <= '0;
            no_lock   <= 1'b0;
        end else begin
            case (state)
                serdes_pkg::st_idle: begin
                    cnt <= '0;
                    if (test_req) begin
                        state <= serdes_pkg::st_wait_lock;
                    end
                end
                serdes_pkg::st_wait_lock: begin
                    if (locked) begin
                        state <= serdes_pkg::st_run;
                        cnt   <= '0;
                    end else if (cnt == `LOCK_TIMEOUT - 1) begin
                        state     <= serdes_pkg::st_done;
                        err_count <= checker_errs;
                        no_lock   <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                serdes_pkg::st_run: begin
                    if (cnt == test_len) begin
                        state     <= serdes_pkg::st_done; // last tick already counted.
                        err_count <= checker_errs;
                        no_lock   <= 1'b0;
                    end else if (word_tick) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                serdes_pkg::st_done: begin
                    if (!test_req) begin
                        state <= serdes_pkg::st_release;
                    end
                end
                default: state <= serdes_pkg::st_idle;
            endcase
        end
    end

endmodule
`default_nettype wire

//--- source/pattern_gen.sv
`timescale 1ns/100ps
`default_nettype none
`include "serdes_macros.svh"

module pattern_gen (
    input  wire        tx_pclk,
    input  wire        rst,
    input  wire        gen_en,
    output logic [7:0] tx_data,
    output logic       tx_k
);

    logic [$clog2(`COMMA_PERIOD)-1:0] pos; // word position in the frame.

    always_ff @(posedge tx_pclk) begin
        if (rst || !gen_en) begin
            pos     <= '0;
            tx_k    <= 1'b1;
            tx_data <= `K28_5_BYTE;
        end else begin
            tx_k    <= (pos == '0);
            tx_data <= (pos == '0) ? `K28_5_BYTE : 8'(pos) - 8'd1;
            pos     <= (pos == `COMMA_PERIOD - 1) ? '0 : pos + 1'b1;
        end
    end

endmodule
`default_nettype wire

//--- source/enc_8b10b.sv
`timescale 1ns/100ps
`default_nettype none
`include "serdes_macros.svh"

module enc_8b10b (
    input  wire        tx_pclk,
    input  wire        rst,
    input  wire  [7:0] tx_data,
    input  wire        tx_k,
    output logic [9:0] tx_symbol
);

    logic       rd;      // running disparity, high when positive.
    logic [4:0] x;
    logic [2:0] y;
    logic [5:0] code6;
    logic [3:0] code4;
    logic       bal6;
    logic       bal4;
    logic       rd_mid;
    logic       rd_next;
    logic       use_a7;

    assign x = tx_data[4:0];
    assign y = tx_data[7:5];

    always_comb begin
        code6  = serdes_pkg::enc_5b6b(x);
        bal6   = ($countones(code6) == 3);
        rd_mid = bal6 ? rd : ~rd;
        if (rd && (!bal6 || x == 5'd7)) begin
            code6 = ~code6;
        end
        // alternate x.7 keeps runs of five equal bits out of the stream.
        use_a7 = (y == 3'd7) &&
                 ((!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                  (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
        code4   = use_a7 ? 4'b0111 : serdes_pkg::enc_3b4b(y);
        bal4    = ($countones(code4) == 2);
        rd_next = bal4 ? rd_mid : ~rd_mid;
        if (rd_mid && (!bal4 || y == 3'd3)) begin
            code4 = ~code4;
        end
    end

    always_ff @(posedge tx_pclk) begin
        if (rst) begin
            rd        <= 1'b0;
            tx_symbol <= `K28_5_RDN;
        end else if (tx_k) begin
            rd        <= ~rd; // only K28.5 is sent, it always flips.
            tx_symbol <= rd ? `K28_5_RDP : `K28_5_RDN;
        end else begin
            rd        <= rd_next;
            tx_symbol <= {code6, code4};
        end
    end

endmodule
`default_nettype wire

//--- source/word_aligner.sv
`timescale 1ns/100ps
`default_nettype none
`include "serdes_macros.svh"

module word_aligner (
    input  wire        tx_pclk,
    input  wire        rst,
    input  wire  [9:0] rx_symbol,
    input  wire        align_restart,
    output logic [9:0] aligned,
    output logic       aligned_valid,
    output logic       locked
);

    logic [9:0]                        prev;
    logic [19:0]                       win;
    logic                              hit;
    logic [3:0]                        hit_off;
    logic [3:0]                        cand_off;
    logic [$clog2(`LOCK_COMMAS+1)-1:0] comma_cnt;
    logic                              lock_now;

    assign win = {prev, rx_symbol}; // offset 0 is the current symbol.

    always_comb begin
        hit     = 1'b0;
        hit_off = 4'd0;
        for (int o = 9; o >= 0; o--) begin
            if (win[o +: 10] == `K28_5_RDN || win[o +: 10] == `K28_5_RDP) begin
                hit     = 1'b1;
                hit_off = 4'(o);
            end
        end
    end

    assign lock_now = !locked && hit && (hit_off == cand_off) &&
                      (comma_cnt == `LOCK_COMMAS - 1);

    always_ff @(posedge tx_pclk) begin
        prev    <= rx_symbol;
        aligned <= win[cand_off +: 10]; // the locking comma comes out first.
    end

    always_ff @(posedge tx_pclk) begin
        if (rst || align_restart) begin
            locked        <= 1'b0;
            aligned_valid <= 1'b0;
            cand_off      <= 4'd0;
            comma_cnt     <= '0;
        end else begin
            aligned_valid <= locked || lock_now;
            if (lock_now) begin
                locked <= 1'b1;
            end
            if (!locked && hit) begin
                if (hit_off == cand_off) begin
                    comma_cnt <= comma_cnt + 1'b1;
                end else begin
                    cand_off  <= hit_off; // new candidate boundary.
                    comma_cnt <= 1'b1;
                end
            end
        end
    end

endmodule
`default_nettype wire

//--- source/dec_8b10b.sv
`timescale 1ns/100ps
`default_nettype none
`include "serdes_macros.svh"

module dec_8b10b (
    input  wire                    tx_pclk,
    input  wire                    rst,
    input  wire  [9:0]             aligned,
    input  wire                    aligned_valid,
    output logic [7:0]             rx_data,
    output serdes_pkg::sym_kind_t  rx_kind,
    output logic                   disp_err,
    output logic                   dec_valid
);

    logic       rd;       // running disparity, high when positive.
    logic       rd_known; // cleared by invalid codes, no check on the next one.
    logic [5:0] c6;
    logic [3:0] c4;
    logic [5:0] n6;
    logic [3:0] n4;
    logic [2:0] ones6;
    logic [2:0] ones4;
    logic [4:0] x;
    logic [2:0] y;
    logic       ok6;
    logic       ok4;
    logic       is_comma;
    logic       good;
    logic       rd_mid;
    logic       rd_next;
    logic       err_d;

    always_comb begin
        c6    = aligned[9:4];
        c4    = aligned[3:0];
        ones6 = 3'($countones(c6));
        ones4 = 3'($countones(c4));
        n6    = (ones6 == 3'd2 || c6 == 6'b000111) ? ~c6 : c6; // fold to rd- form.
        n4    = (ones4 == 3'd1 || c4 == 4'b0011) ? ~c4 : c4;
        ok6   = 1'b0;
        x     = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (serdes_pkg::enc_5b6b(5'(i)) == n6) begin
                ok6 = 1'b1;
                x   = 5'(i);
            end
        end
        ok4 = (ones4 != 3'd0) && (ones4 != 3'd4);
        y   = (n4 == 4'b0111) ? 3'd7 : 3'd0; // alternate x.7.
        for (int j = 0; j < 8; j++) begin
            if (serdes_pkg::enc_3b4b(3'(j)) == n4) begin
                y = 3'(j);
            end
        end
        is_comma = (aligned == `K28_5_RDN) || (aligned == `K28_5_RDP);
        good     = is_comma || (ok6 && ok4);
        rd_mid   = (ones6 == 3'd4) ? 1'b1 : (ones6 == 3'd2) ? 1'b0 : rd;
        rd_next  = (ones4 == 3'd3) ? 1'b1 : (ones4 == 3'd1) ? 1'b0 : rd_mid;
        err_d    = ((ones6 == 3'd4 || c6 == 6'b111000) && rd) ||
                   ((ones6 == 3'd2 || c6 == 6'b000111) && !rd) ||
                   ((ones4 == 3'd3 || c4 == 4'b1100) && rd_mid) ||
                   ((ones4 == 3'd1 || c4 == 4'b0011) && !rd_mid);
    end

    always_ff @(posedge tx_pclk) begin
        if (rst) begin
            rd        <= 1'b0;
            rd_known  <= 1'b0;
            disp_err  <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= aligned_valid;
            disp_err  <= aligned_valid && rd_known && good && err_d;
            if (aligned_valid && good) begin
                rd <= rd_next;
            end
            rd_known <= aligned_valid && good;
        end
    end

    always_ff @(posedge tx_pclk) begin
        rx_data <= is_comma ? `K28_5_BYTE : {y, x};
        rx_kind <= is_comma ? serdes_pkg::sym_comma :
                   good     ? serdes_pkg::sym_data  : serdes_pkg::sym_invalid;
    end

endmodule
`default_nettype wire

//--- source/pattern_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "serdes_macros.svh"

module pattern_checker (
    input  wire                   tx_pclk,
    input  wire                   rst,
    input  wire                   chk_en,
    input  wire                   chk_clear,
    input  wire  [7:0]            rx_data,
    input  var serdes_pkg::sym_kind_t rx_kind,
    input  wire                   disp_err,
    input  wire                   dec_valid,
    output logic                  word_tick,
    output logic [`LEN_W-1:0]     err_count
);

    logic [7:0] expected;
    logic       synced; // a comma has been seen since the last clear.
    logic       is_comma;
    logic       bad;

    assign is_comma = (rx_kind == serdes_pkg::sym_comma);
    assign bad      = (rx_kind == serdes_pkg::sym_invalid) || disp_err ||
                      (rx_data != expected);

    always_ff @(posedge tx_pclk) begin
        if (dec_valid) begin
            expected <= is_comma ? 8'd0 : expected + 8'd1;
        end
    end

    always_ff @(posedge tx_pclk) begin
        if (rst || chk_clear) begin
            synced    <= 1'b0;
            word_tick <= 1'b0;
            err_count <= '0;
        end else begin
            word_tick <= 1'b0;
            if (dec_valid && is_comma) begin
                synced <= 1'b1;
            end else if (dec_valid && synced && chk_en) begin
                word_tick <= 1'b1;
                if (bad && err_count != '1) begin
                    err_count <= err_count + 1'b1; // saturates.
                end
            end
        end
    end

endmodule
`default_nettype wire

//--- source/serdes_link_test.sv
`timescale 1ns/100ps
`default_nettype none
`include "serdes_macros.svh"

module serdes_link_test (
    input  wire               tx_pclk,
    input  wire               rst,
    input  wire               test_req,
    input  wire  [`LEN_W-1:0] test_len,
    output logic              test_ack,
    output logic [`LEN_W-1:0] err_count,
    output logic              no_lock,
    output logic [9:0]        tx_symbol,
    input  wire  [9:0]        rx_symbol
);

    logic                  gen_en;
    logic                  chk_en;
    logic                  chk_clear;
    logic                  align_restart;
    logic [7:0]            tx_data;
    logic                  tx_k;
    logic [9:0]            aligned;
    logic                  aligned_valid;
    logic                  locked;
    logic [7:0]            rx_data;
    serdes_pkg::sym_kind_t rx_kind;
    logic                  disp_err;
    logic                  dec_valid;
    logic                  word_tick;
    logic [`LEN_W-1:0]     chk_errs;

    link_ctrl ctrl0 (
        .tx_pclk(tx_pclk), .rst(rst),
        .test_req(test_req), .test_len(test_len),
        .locked(locked), .word_tick(word_tick), .checker_errs(chk_errs),
        .test_ack(test_ack), .err_count(err_count), .no_lock(no_lock),
        .gen_en(gen_en), .chk_en(chk_en), .chk_clear(chk_clear),
        .align_restart(align_restart)
    );

    pattern_gen gen0 (
        .tx_pclk(tx_pclk), .rst(rst), .gen_en(gen_en),
        .tx_data(tx_data), .tx_k(tx_k)
    );

    enc_8b10b enc0 (
        .tx_pclk(tx_pclk), .rst(rst),
        .tx_data(tx_data), .tx_k(tx_k), .tx_symbol(tx_symbol)
    );

    word_aligner align0 (
        .tx_pclk(tx_pclk), .rst(rst),
        .rx_symbol(rx_symbol), .align_restart(align_restart),
        .aligned(aligned), .aligned_valid(aligned_valid), .locked(locked)
    );

    dec_8b10b dec0 (
        .tx_pclk(tx_pclk), .rst(rst),
        .aligned(aligned), .aligned_valid(aligned_valid),
        .rx_data(rx_data), .rx_kind(rx_kind),
        .disp_err(disp_err), .dec_valid(dec_valid)
    );

    pattern_checker chk0 (
        .tx_pclk(tx_pclk), .rst(rst),
        .chk_en(chk_en), .chk_clear(chk_clear),
        .rx_data(rx_data), .rx_kind(rx_kind),
        .disp_err(disp_err), .dec_valid(dec_valid),
        .word_tick(word_tick), .err_count(chk_errs)
    );

endmodule
`default_nettype wire

//--- verification/serdes_link_test_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module serdes_link_test_asserts (
    input wire       tx_pclk,
    input wire       rst,
    input wire       test_req,
    input wire       test_ack,
    input wire [9:0] tx_symbol,
    input wire       locked,
    input wire       align_restart
);

    int unsigned violations = 0; // failed assertions so far.

    ack_needs_req: assert property (@(posedge tx_pclk) disable iff (rst)
        $rose(test_ack) |-> test_req)
        else begin
            violations++;
            $error("test_ack rose while test_req was low");
        end

    symbol_balance: assert property (@(posedge tx_pclk) disable iff (rst)
        $countones(tx_symbol) inside {[4:6]})
        else begin
            violations++;
            $error("tx_symbol %b has an illegal number of ones", tx_symbol);
        end

    // the boundary lock only drops on reset or a restart request.
    lock_holds: assert property (@(posedge tx_pclk) disable iff (rst)
        $fell(locked) |-> ($past(rst) || $past(align_restart)))
        else begin
            violations++;
            $error("locked fell without rst or align_restart");
        end

endmodule

bind serdes_link_test serdes_link_test_asserts asserts0 (
    .tx_pclk(tx_pclk), .rst(rst),
    .test_req(test_req), .test_ack(test_ack),
    .tx_symbol(tx_symbol), .locked(locked), .align_restart(align_restart)
);
`default_nettype wire

//--- verification/serdes_link_test_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "serdes_macros.svh"

module serdes_link_test_tb;

    localparam int sum_len     = 1900;
    localparam int run_count   = 7;
    localparam int cycle_limit = 2 * (sum_len + run_count * `LOCK_TIMEOUT);

    logic              tx_pclk;
    logic              rst;
    logic              test_req;
    logic [`LEN_W-1:0] test_len;
    logic              test_ack;
    logic [`LEN_W-1:0] err_count;
    logic              no_lock;
    logic [9:0]        tx_symbol;
    logic [9:0]        rx_symbol;

    int                cycle_count;
    int                rotation;   // bit offset seen by the receiver.
    logic              hold_line;  // rx stuck at hold_value.
    logic [9:0]        hold_value;
    int                data_idx;   // data symbols sent since the line was set up.
    bit                corrupt_mark [0:1023];
    logic [9:0]        line_pipe [0:1];
    logic [19:0]       rot_win;
    logic [`LEN_W-1:0] got_errs;
    logic              got_no_lock;

    serdes_link_test dut0 (
        .tx_pclk(tx_pclk), .rst(rst),
        .test_req(test_req), .test_len(test_len),
        .test_ack(test_ack), .err_count(err_count), .no_lock(no_lock),
        .tx_symbol(tx_symbol), .rx_symbol(rx_symbol)
    );

    initial begin
        tx_pclk = 1'b0;
        forever #10 tx_pclk = ~tx_pclk;
    end

    // loopback line, two register stages and then a rotating 20-bit window.
    always begin
        logic [9:0] sent;
        @(posedge tx_pclk);
        #2;
        sent = tx_symbol;
        if (tx_symbol != `K28_5_RDN && tx_symbol != `K28_5_RDP) begin
            if (data_idx < 1024 && corrupt_mark[data_idx]) begin
                sent = 10'd0; // no valid 6b code has zero ones.
            end
            data_idx++;
        end
        rot_win      = {rot_win[9:0], line_pipe[1]};
        line_pipe[1] = line_pipe[0];
        line_pipe[0] = sent;
        rx_symbol    = hold_line ? hold_value : rot_win[rotation +: 10];
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge tx_pclk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
        $display("Result: FAILED");
        $fatal(1, "run stopped by the cycle limit");
    end

    task automatic step();
        @(posedge tx_pclk);
        #2;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // only called while the line carries commas.
    task automatic set_line(input int rot, input logic hold);
        rotation  = rot;
        hold_line = hold;
        data_idx  = 0;
        foreach (corrupt_mark[i]) begin
            corrupt_mark[i] = 1'b0;
        end
        repeat (4) step();
    endtask

    task automatic mark_corruptions(input int k, input int first, input int stride,
                                    input int spread);
        for (int i = 0; i < k; i++) begin
            corrupt_mark[first + i * stride + int'($urandom % spread)] = 1'b1;
        end
    endtask

    task automatic run_link_test(input int len, output logic [`LEN_W-1:0] errs,
                                 output logic lost);
        test_len = `LEN_W'(len);
        test_req = 1'b1;
        step();
        while (test_ack !== 1'b1) begin
            step();
        end
        errs = err_count;
        lost = no_lock;
        repeat (3) begin
            step();
            check_value("test_ack while test_req is high", test_ack, 1);
        end
        test_req = 1'b0;
        step();
        check_value("test_ack after test_req fell", test_ack, 0);
        step();
    endtask

    task automatic clean_loopback_test();
        check_value("test_ack after reset", test_ack, 0);
        check_value("no_lock after reset", no_lock, 0);
        check_value("tx_symbol after reset", tx_symbol, `K28_5_RDN);
        set_line(0, 1'b0);
        run_link_test(200, got_errs, got_no_lock);
        check_value("clean err_count", got_errs, 0);
        check_value("clean no_lock", got_no_lock, 0);
    endtask

    task automatic rotation_test();
        for (int rot = 3; rot <= 7; rot += 4) begin
            set_line(rot, 1'b0);
            run_link_test(200, got_errs, got_no_lock);
            check_value($sformatf("err_count at rotation %0d", rot), got_errs, 0);
            check_value($sformatf("no_lock at rotation %0d", rot), got_no_lock, 0);
        end
    endtask

    // corrupted words stay inside the checked window, at least two frames apart.
    task automatic corruption_test(input int k, input int len, input int stride,
                                   input int spread);
        set_line(0, 1'b0);
        mark_corruptions(k, 90, stride, spread);
        run_link_test(len, got_errs, got_no_lock);
        check_value("err_count with corrupted words", got_errs, k);
        check_value("no_lock with corrupted words", got_no_lock, 0);
    endtask

    task automatic stuck_line_test();
        set_line(0, 1'b1);
        run_link_test(100, got_errs, got_no_lock);
        check_value("no_lock on a stuck line", got_no_lock, 1);
        check_value("err_count on a stuck line", got_errs, 0);
    endtask

    task automatic back_to_back_test();
        corruption_test(3, 300, 60, 28);
        set_line(0, 1'b0);
        run_link_test(300, got_errs, got_no_lock);
        check_value("err_count of the clean run after errors", got_errs, 0);
        check_value("no_lock of the clean run after errors", got_no_lock, 0);
    endtask

    initial begin
        void'($urandom(32'h7533));
        rst          = 1'b1;
        test_req     = 1'b0;
        test_len     = '0;
        rx_symbol    = `K28_5_RDN;
        rotation     = 0;
        hold_line    = 1'b0;
        hold_value   = 10'b0101010101; // holds no comma at any offset.
        data_idx     = 0;
        line_pipe[0] = `K28_5_RDN;
        line_pipe[1] = `K28_5_RDN;
        rot_win      = {2{`K28_5_RDN}};
        foreach (corrupt_mark[i]) begin
            corrupt_mark[i] = 1'b0;
        end
        repeat (3) @(posedge tx_pclk);
        #2;
        rst = 1'b0;
        clean_loopback_test();
        rotation_test();
        corruption_test(5, 600, 90, 50);
        stuck_line_test();
        back_to_back_test();
        if (dut0.asserts0.violations == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
`default_nettype wire

//--- serdes_link_test.f
+incdir+source
source/serdes_pkg.sv
source/link_ctrl.sv
source/pattern_gen.sv
source/enc_8b10b.sv
source/word_aligner.sv
source/dec_8b10b.sv
source/pattern_checker.sv
source/serdes_link_test.sv
verification/serdes_link_test_asserts.sv
verification/serdes_link_test_tb.sv
